/* verilog/fcs_cfg.svh */
// frame length, FCS size and CRC-32 constants for the FCS inserter
`ifndef FCS_CFG_SVH
`define FCS_CFG_SVH

// minimum Ethernet frame length, FCS included
`define FCS_MIN_FRAME_LEN 64

// length of the frame check sequence in bytes
`define FCS_BYTES 4

// payload must reach this length before the FCS is appended
`define FCS_MIN_PAYLOAD (`FCS_MIN_FRAME_LEN - `FCS_BYTES)

// reflected form of the Ethernet polynomial 0x04c11db7
`define FCS_CRC_POLY 32'hedb88320
`define FCS_CRC_SEED 32'hffffffff

// frame byte counter width
`define FCS_LEN_W 16

`endif

/* verilog/fcs_pkg.sv */
// control state and length command enums, stream beat and FCS split structs
`default_nettype none

package fcs_pkg;

    // frame walk of the inserter
    typedef enum logic [1:0] {
        state_idle,
        state_payload,
        state_pad,
        state_fcs
    } fcs_state_e;

    // commands to the frame length counter
    typedef enum logic [2:0] {
        len_hold,
        len_clear,
        len_start,
        len_add,
        len_pad
    } len_op_e;

    // one 64-bit stream beat, lane 0 in data[7:0]
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } axis_beat_t;

    // last beat with the FCS merged in, plus the overflow beat
    typedef struct packed {
        logic [63:0] data0;
        logic [7:0]  keep0;
        logic [63:0] data1;
        logic [7:0]  keep1;
    } fcs_split_t;

endpackage

`default_nettype wire

/* verilog/fcs_ctrl.sv */
// frame state machine steering CRC, length counter and output beat
`timescale 1ns/1ps
`default_nettype none

module fcs_ctrl import fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    output axis_beat_t crc_beat,
    output logic       crc_clear,
    output logic       crc_update,
    input  fcs_split_t fcs,
    output len_op_e    len_op,
    input  logic       short_next,
    input  logic [7:0] pad_keep,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       early_ready,
    input  logic       int_ready
);

    fcs_state_e  state, state_next;
    logic        s_ready_reg, s_ready_next;
    logic [63:0] spill_data, spill_data_next;
    logic [7:0]  spill_keep, spill_keep_next;
    logic [63:0] data_m;
    logic        take;
    logic        finish;

    assign s_ready = s_ready_reg;
    assign take    = s_valid && s_ready_reg;

    // zero the lanes the source disabled
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            data_m[8*i +: 8] = s_beat.keep[i] ? s_beat.data[8*i +: 8] : 8'd0;
        end
    end

    always_comb begin
        state_next      = state;
        s_ready_next    = 1'b0;
        spill_data_next = spill_data;
        spill_keep_next = spill_keep;
        crc_clear       = 1'b0;
        crc_update      = 1'b0;
        len_op          = len_hold;
        crc_beat        = '0;
        out_beat        = '0;
        out_valid       = 1'b0;
        finish          = 1'b0;

        case (state)
            state_idle, state_payload: begin
                s_ready_next  = early_ready;
                crc_beat.data = data_m;
                crc_beat.keep = s_beat.keep;
                out_beat.data = data_m;
                out_beat.keep = s_beat.keep;
                out_valid     = take;
                if (state == state_idle) begin
                    crc_clear = 1'b1;
                    len_op    = len_clear;
                end
                if (take) begin
                    crc_clear = 1'b0;
                    if (!s_beat.last) begin
                        crc_update = 1'b1;
                        len_op     = (state == state_idle) ? len_start : len_add;
                        state_next = state_payload;
                    end else if (s_beat.user) begin
                        // errored frame passes through without pad or FCS
                        out_beat.last = 1'b1;
                        out_beat.user = 1'b1;
                        crc_clear     = 1'b1;
                        len_op        = len_clear;
                        state_next    = state_idle;
                    end else begin
                        finish = 1'b1;
                    end
                end
            end
            state_pad: begin
                // pad lanes come entirely from pad_keep below
                out_valid = int_ready;
                finish    = int_ready;
            end
            state_fcs: begin
                out_beat.data = spill_data;
                out_beat.keep = spill_keep;
                out_beat.last = 1'b1;
                out_valid     = int_ready;
                if (int_ready) begin
                    s_ready_next = early_ready;
                    state_next   = state_idle;
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase

        // good frame end or one pad beat
        if (finish) begin
            // source stays stalled until the frame is closed
            s_ready_next  = 1'b0;
            crc_beat.keep = crc_beat.keep | pad_keep;
            out_beat.keep = crc_beat.keep;
            len_op        = len_pad;
            if (short_next) begin
                crc_update = 1'b1;
                state_next = state_pad;
            end else begin
                crc_clear     = 1'b1;
                out_beat.data = fcs.data0;
                out_beat.keep = fcs.keep0;
                if (fcs.keep1 == 8'd0) begin
                    out_beat.last = 1'b1;
                    s_ready_next  = early_ready;
                    state_next    = state_idle;
                end else begin
                    // FCS overflows into one more beat
                    spill_data_next = fcs.data1;
                    spill_keep_next = fcs.keep1;
                    state_next      = state_fcs;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= state_idle;
            s_ready_reg <= 1'b0;
        end else begin
            state       <= state_next;
            s_ready_reg <= s_ready_next;
        end
    end

    always_ff @(posedge clk) begin
        spill_data <= spill_data_next;
        spill_keep <= spill_keep_next;
    end

endmodule

`default_nettype wire

/* verilog/frame_len_counter.sv */
// running frame byte count with below-minimum flag and final pad keep
`timescale 1ns/1ps
`default_nettype none

`include "fcs_cfg.svh"

module frame_len_counter import fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  len_op_e    len_op,
    input  logic [7:0] keep,
    output logic       short_next,
    output logic [7:0] pad_keep
);

    logic [`FCS_LEN_W-1:0] count;
    logic [`FCS_LEN_W-1:0] len_next;
    logic [`FCS_LEN_W-1:0] room;
    logic [3:0]            lanes;

    // enabled lanes, counted up to the highest set bit
    always_comb begin
        lanes = 4'd0;
        for (int i = 0; i < 8; i++) begin
            if (keep[i]) begin
                lanes = 4'(i + 1);
            end
        end
    end

    always_comb begin
        case (len_op)
            len_clear: len_next = '0;
            len_start: len_next = `FCS_LEN_W'(lanes);
            len_add:   len_next = count + `FCS_LEN_W'(lanes);
            len_pad:   len_next = count + `FCS_LEN_W'(8);
            default:   len_next = count;
        endcase
    end

    assign short_next = (len_next < `FCS_MIN_PAYLOAD);

    // lanes still missing up to the minimum payload
    assign room = `FCS_LEN_W'(`FCS_MIN_PAYLOAD) - count;

    always_comb begin
        if (count >= `FCS_MIN_PAYLOAD) begin
            pad_keep = 8'h00;
        end else if (room >= `FCS_LEN_W'(8)) begin
            pad_keep = 8'hff;
        end else begin
            pad_keep = 8'hff >> (4'd8 - room[3:0]);
        end
    end

    // a pad step that reaches the minimum closes the frame
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (len_op == len_pad && !short_next) begin
            count <= '0;
        end else begin
            count <= len_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/crc32_unit.sv */
// CRC-32 register, per-lane-count next values and FCS merge into the last beats
`timescale 1ns/1ps
`default_nettype none

`include "fcs_cfg.svh"

module crc32_unit import fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t crc_beat,
    input  logic       crc_clear,
    input  logic       crc_update,
    output fcs_split_t fcs
);

    logic [31:0] crc_reg;
    logic [31:0] crc_chain [0:8];
    logic [31:0] fcs_word;
    logic [3:0]  lanes;
    logic [63:0] data_low;
    logic [95:0] merged;
    logic [11:0] merged_keep;

    // one byte through the reflected LFSR, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ `FCS_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // crc_chain[n] covers the low n lanes of the beat
    always_comb begin
        crc_chain[0] = crc_reg;
        for (int n = 1; n <= 8; n++) begin
            crc_chain[n] = crc_byte(crc_chain[n-1], crc_beat.data[8*(n-1) +: 8]);
        end
    end

    always_comb begin
        lanes = 4'd0;
        for (int i = 0; i < 8; i++) begin
            if (crc_beat.keep[i]) begin
                lanes = 4'(i + 1);
            end
        end
    end

    assign fcs_word = ~crc_chain[lanes];

    // FCS goes right after the last valid byte, LSB first
    assign data_low    = crc_beat.data & ~({64{1'b1}} << (8 * lanes));
    assign merged      = ({64'd0, fcs_word} << (8 * lanes)) | {32'd0, data_low};
    assign merged_keep = ~(12'hfff << (lanes + 4'(`FCS_BYTES)));

    // lane counts above 4 push 1 to 4 bytes into the spill beat
    always_comb begin
        fcs.data0 = merged[63:0];
        fcs.keep0 = merged_keep[7:0];
        fcs.data1 = {32'd0, merged[95:64]};
        fcs.keep1 = {4'd0, merged_keep[11:8]};
    end

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc_reg <= `FCS_CRC_SEED;
        end else if (crc_update) begin
            crc_reg <= crc_chain[8];
        end
    end

endmodule

`default_nettype wire

/* verilog/axis_out_stage.sv */
// output register with spare register and registered early ready
`timescale 1ns/1ps
`default_nettype none

module axis_out_stage import fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       early_ready,
    output logic       int_ready,
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    axis_beat_t out_reg;
    axis_beat_t spare_reg;
    logic       out_valid, out_valid_next;
    logic       spare_valid, spare_valid_next;
    logic       int_ready_reg;
    logic       load_out;
    logic       load_spare;
    logic       spare_to_out;

    assign m_beat    = out_reg;
    assign m_valid   = out_valid;
    assign int_ready = int_ready_reg;

    // spare cannot fill next cycle, or the sink drains this cycle
    assign early_ready = m_ready || (!spare_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next   = out_valid;
        spare_valid_next = spare_valid;
        load_out         = 1'b0;
        load_spare       = 1'b0;
        spare_to_out     = 1'b0;

        if (int_ready_reg) begin
            if (m_ready || !out_valid) begin
                out_valid_next = in_valid;
                load_out       = 1'b1;
            end else begin
                // beat in flight while the sink stalls
                spare_valid_next = in_valid;
                load_spare       = 1'b1;
            end
        end else if (m_ready) begin
            out_valid_next   = spare_valid;
            spare_valid_next = 1'b0;
            spare_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid     <= 1'b0;
            spare_valid   <= 1'b0;
            int_ready_reg <= 1'b0;
        end else begin
            out_valid     <= out_valid_next;
            spare_valid   <= spare_valid_next;
            int_ready_reg <= early_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_reg <= in_beat;
        end else if (spare_to_out) begin
            out_reg <= spare_reg;
        end
        if (load_spare) begin
            spare_reg <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* verilog/fcs_insert_top.sv */
// FCS inserter top: control, length counter, CRC unit and output stage
`timescale 1ns/1ps
`default_nettype none

module fcs_insert_top import fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    axis_beat_t crc_beat;
    axis_beat_t out_beat;
    fcs_split_t fcs;
    len_op_e    len_op;
    logic       crc_clear;
    logic       crc_update;
    logic       short_next;
    logic [7:0] pad_keep;
    logic       out_valid;
    logic       early_ready;
    logic       int_ready;

    fcs_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .crc_beat    (crc_beat),
        .crc_clear   (crc_clear),
        .crc_update  (crc_update),
        .fcs         (fcs),
        .len_op      (len_op),
        .short_next  (short_next),
        .pad_keep    (pad_keep),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .early_ready (early_ready),
        .int_ready   (int_ready)
    );

    frame_len_counter u_len (
        .clk        (clk),
        .rst        (rst),
        .len_op     (len_op),
        .keep       (s_beat.keep),
        .short_next (short_next),
        .pad_keep   (pad_keep)
    );

    crc32_unit u_crc (
        .clk        (clk),
        .rst        (rst),
        .crc_beat   (crc_beat),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .fcs        (fcs)
    );

    axis_out_stage u_out (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (out_beat),
        .in_valid    (out_valid),
        .early_ready (early_ready),
        .int_ready   (int_ready),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule

`default_nettype wire

/* testbench/tb_fcs_insert.sv */
// testbench for the FCS inserter: frame source, sink back-pressure, reference model, monitor
`timescale 1ns/1ps
`default_nettype none

`include "fcs_cfg.svh"

module tb_fcs_insert import fcs_pkg::*; ();

    typedef logic [7:0] byte_q_t [$];

    logic       clk = 1'b0;
    logic       rst;
    axis_beat_t s_beat;
    logic       s_valid;
    logic       s_ready;
    axis_beat_t m_beat;
    logic       m_valid;
    logic       m_ready;

    integer     seed = 32'hd996;
    logic [1:0] sink_mode = 2'd0;
    int         errors = 0;
    int         checks = 0;
    int         tests_failed = 0;
    int         frames_sent = 0;
    int         frames_done = 0;

    // expected output, flat bytes plus per-frame length, error flag and beat count
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    logic       exp_err [$];
    int         exp_beats [$];
    logic [7:0] mon_bytes [$];
    int         mon_beats = 0;

    fcs_insert_top UUT (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    always #2 clk = ~clk;

    // sink: 0 stalls, 1 always ready, 2 random back-pressure
    always @(negedge clk) begin
        case (sink_mode)
            2'd0: m_ready = 1'b0;
            2'd1: m_ready = 1'b1;
            default: m_ready = (($random(seed) & 3) != 0);
        endcase
    end

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // bitwise reflected CRC-32, seed all ones, result inverted
    function automatic logic [31:0] crc32_ref(input byte_q_t bytes);
        logic [31:0] crc;
        logic        fb;
        crc = `FCS_CRC_SEED;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ bytes[i][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ `FCS_CRC_POLY;
                end
            end
        end
        return ~crc;
    endfunction

    // expected output bytes for one frame
    function automatic byte_q_t ref_frame(input byte_q_t payload, input logic err);
        byte_q_t     result;
        logic [31:0] crc;
        result = payload;
        if (!err) begin
            while (result.size() < `FCS_MIN_PAYLOAD) begin
                result.push_back(8'h00);
            end
            crc = crc32_ref(result);
            for (int k = 0; k < `FCS_BYTES; k++) begin
                result.push_back(crc[8*k +: 8]);
            end
        end
        return result;
    endfunction

    function automatic byte_q_t pattern_payload(input int len, input int base);
        byte_q_t p;
        for (int i = 0; i < len; i++) begin
            p.push_back(8'((base + 13 * i) | 1));
        end
        return p;
    endfunction

    // called on a falling edge; returns on the falling edge after the transfer
    task automatic send_beat(input axis_beat_t beat);
        int waited;
        waited  = 0;
        s_beat  = beat;
        s_valid = 1'b1;
        while (!s_ready && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (!s_ready) begin
            abort_on_timeout("s_ready");
        end
        @(negedge clk);
    endtask

    task automatic send_frame(input byte_q_t payload, input logic err);
        byte_q_t    expv;
        axis_beat_t beat;
        int         nbeats;
        int         n;
        expv = ref_frame(payload, err);
        foreach (expv[i]) begin
            exp_bytes.push_back(expv[i]);
        end
        exp_len.push_back(expv.size());
        exp_err.push_back(err);
        exp_beats.push_back((expv.size() + 7) / 8);
        frames_sent++;
        nbeats = (payload.size() + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            n = payload.size() - 8 * b;
            if (n > 8) begin
                n = 8;
            end
            // junk in the disabled lanes, must not reach the output
            for (int i = 0; i < 8; i++) begin
                beat.data[8*i +: 8] = (i < n) ? payload[8*b + i] : 8'(8'h5a ^ i);
            end
            beat.keep = 8'hff >> (8 - n);
            beat.last = (b == nbeats - 1);
            beat.user = err && beat.last;
            send_beat(beat);
        end
    endtask

    task automatic wait_frames_done(input int limit);
        int waited;
        waited = 0;
        s_valid = 1'b0;
        s_beat  = '0;
        while (frames_done < frames_sent && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (frames_done < frames_sent) begin
            abort_on_timeout("output frames");
        end
    endtask

    task automatic compare_frame(input logic user);
        int         n;
        int         nb;
        logic       err;
        logic [7:0] eb;
        bit         bad;
        n   = exp_len.pop_front();
        err = exp_err.pop_front();
        nb  = exp_beats.pop_front();
        bad = 0;
        check_value("frame byte count", mon_bytes.size(), n);
        check_value("frame beat count", mon_beats, nb);
        check_value("m_beat.user on last", user, err);
        for (int i = 0; i < n; i++) begin
            eb = exp_bytes.pop_front();
            if (!bad && i < mon_bytes.size() && mon_bytes[i] !== eb) begin
                bad = 1;
                check_value($sformatf("m_beat.data byte %0d", i), mon_bytes[i], eb);
            end
        end
    endtask

    // collect transferred output beats and close a frame on last
    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            mon_beats++;
            for (int i = 0; i < 8; i++) begin
                if (m_beat.keep[i]) begin
                    mon_bytes.push_back(m_beat.data[8*i +: 8]);
                end
            end
            if (!m_beat.last) begin
                check_value("m_beat.user", m_beat.user, 0);
            end else begin
                assert (exp_len.size() != 0) else begin
                    $display("output frame ended at %0t while no frame was expected", $time);
                    errors++;
                end
                if (exp_len.size() != 0) begin
                    compare_frame(m_beat.user);
                end
                mon_bytes.delete();
                mon_beats = 0;
                frames_done++;
            end
        end
    end

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%-30s passed", name);
        end else begin
            $display("%-30s failed with %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        int      e0;
        int      waited;
        int      len;
        logic    err;
        byte_q_t p;
        rst     = 1'b1;
        s_valid = 1'b0;
        s_beat  = '0;
        m_ready = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        check_value("m_valid", m_valid, 0);
        check_value("s_ready", s_ready, 0);
        sink_mode <= 2'd1;
        waited = 0;
        while (!s_ready && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!s_ready) begin
            abort_on_timeout("s_ready after reset");
        end
        check_value("m_valid", m_valid, 0);
        finish_test("test 1 reset and ready", e0);

        // every lane count of the final beat
        e0 = errors;
        for (int l = 64; l <= 71; l++) begin
            send_frame(pattern_payload(l, l), 1'b0);
        end
        wait_frames_done(2000);
        finish_test("test 2 last beat lane counts", e0);

        e0 = errors;
        send_frame(pattern_payload(1, 3), 1'b0);
        send_frame(pattern_payload(20, 5), 1'b0);
        send_frame(pattern_payload(59, 7), 1'b0);
        send_frame(pattern_payload(60, 9), 1'b0);
        wait_frames_done(2000);
        finish_test("test 3 short frame padding", e0);

        e0 = errors;
        send_frame(pattern_payload(13, 11), 1'b1);
        send_frame(pattern_payload(70, 17), 1'b1);
        send_frame(pattern_payload(5, 19), 1'b1);
        send_frame(pattern_payload(45, 23), 1'b0);
        wait_frames_done(2000);
        finish_test("test 4 errored frames", e0);

        // random lengths, back-to-back, random sink stalls
        e0 = errors;
        sink_mode <= 2'd2;
        for (int f = 0; f < 24; f++) begin
            len = 1 + ($random(seed) & 127);
            err = (($random(seed) & 7) == 0);
            p.delete();
            for (int i = 0; i < len; i++) begin
                p.push_back(8'($random(seed)));
            end
            send_frame(p, err);
        end
        wait_frames_done(10000);
        sink_mode <= 2'd1;
        repeat (20) @(negedge clk);
        check_value("leftover output bytes", mon_bytes.size(), 0);
        check_value("frames still expected", exp_len.size(), 0);
        finish_test("test 5 random back-pressure", e0);

        $display("5 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/fcs_pkg.sv
verilog/fcs_ctrl.sv
verilog/frame_len_counter.sv
verilog/crc32_unit.sv
verilog/axis_out_stage.sv
verilog/fcs_insert_top.sv
testbench/tb_fcs_insert.sv

/* Bender.yml */
package:
  name: fcs_insert

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fcs_pkg.sv
      - verilog/fcs_ctrl.sv
      - verilog/frame_len_counter.sv
      - verilog/crc32_unit.sv
      - verilog/axis_out_stage.sv
      - verilog/fcs_insert_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_fcs_insert.sv
